// File: uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Host command word, wr sits in bit 15
  typedef struct packed {
    logic       wr;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // Read result returned to the host
  typedef struct packed {
    logic [7:0] data;
    logic       err;
  } rsp_t;

  typedef logic [7:0] frame_byte_t;

  // Idle bit periods between header and data frame of a write
  localparam int gap_bits = 2;

  // Bit that makes the count of ones in byte plus parity even
  function automatic logic even_parity(input frame_byte_t b);
    logic p;
    p = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      p = p ^ b[i];
    end
    return p;
  endfunction

endpackage

// File: cmd_intake.sv
module cmd_intake (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               idle,
  output logic               cmd_ack,
  output logic               cmd_valid,
  output uart_cmd_pkg::cmd_t held_cmd
);

  logic accept;

  // New request only while the sequencer has nothing in flight
  assign accept = cmd_req && !cmd_ack && idle;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_ack   <= 1'b0;
      cmd_valid <= 1'b0;
    end
    else
    begin
      cmd_valid <= accept;                // One cycle pulse at latch
      if (accept)
        cmd_ack <= 1'b1;
      else if (!cmd_req)
        cmd_ack <= 1'b0;                  // Host released, close handshake
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      held_cmd <= cmd;                    // Held until the next accept
  end

  // Ack never rises while the request is low
  a_ack_after_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cmd_ack) |-> cmd_req
  );

endmodule

// File: cmd_sequencer.sv
module cmd_sequencer #(
  parameter int bit_cycles = 434
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_valid,
  input  uart_cmd_pkg::cmd_t        held_cmd,
  input  logic                      tx_busy,
  input  logic                      rx_done,
  input  uart_cmd_pkg::frame_byte_t rx_byte,
  input  logic                      rx_err,
  input  logic                      rsp_busy,
  output logic                      idle,
  output logic                      tx_start,
  output uart_cmd_pkg::frame_byte_t tx_byte,
  output logic                      rx_enable,
  output logic                      rsp_load,
  output uart_cmd_pkg::rsp_t        rsp_word
);
  import uart_cmd_pkg::*;

  localparam int gap_cycles = gap_bits * bit_cycles;
  localparam int gap_w      = $clog2(gap_cycles);
  localparam logic [gap_w-1:0] gap_last = gap_w'(gap_cycles - 1);

  typedef enum logic [3:0] {
    s_idle,
    s_hdr,
    s_hdr_wait,
    s_gap,
    s_data,
    s_data_wait,
    s_rx,
    s_rsp,
    s_rsp_wait
  } state_t;

  state_t           state;
  logic [gap_w-1:0] gap_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= s_idle;
      gap_cnt <= '0;
    end
    else
    begin
      case (state)
        s_idle:
          if (cmd_valid)
            state <= s_hdr;
        s_hdr:
          state <= s_hdr_wait;            // Busy is up from here on
        s_hdr_wait:
          if (!tx_busy)
          begin
            gap_cnt <= '0;
            state   <= held_cmd.wr ? s_gap : s_rx;
          end
        s_gap:
          if (gap_cnt == gap_last)
            state <= s_data;
          else
            gap_cnt <= gap_cnt + 1'b1;
        s_data:
          state <= s_data_wait;
        s_data_wait:
          if (!tx_busy)
            state <= s_idle;
        s_rx:
          if (rx_done)
            state <= s_rsp;
        s_rsp:
          state <= s_rsp_wait;
        s_rsp_wait:
          if (!rsp_busy)
            state <= s_idle;              // Host finished all four phases
        default:
          state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == s_rx && rx_done)
      rsp_word <= '{data: rx_byte, err: rx_err};
  end

  assign idle     = (state == s_idle);
  assign tx_start = (state == s_hdr) || (state == s_data);
  assign tx_byte  = (state == s_data) ? held_cmd.data : {held_cmd.wr, held_cmd.addr};
  assign rsp_load = (state == s_rsp);

  // Armed during the header too, so a fast peer reply is not missed
  assign rx_enable = (state == s_rx) || (state == s_hdr_wait && !held_cmd.wr);

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  );

endmodule

// File: uart_tx_frame.sv
module uart_tx_frame #(
  parameter int bit_cycles = 434
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      tx_start,
  input  uart_cmd_pkg::frame_byte_t tx_byte,
  output logic                      tx,
  output logic                      tx_busy
);
  import uart_cmd_pkg::*;

  localparam int cnt_w = $clog2(bit_cycles);
  localparam logic [cnt_w-1:0] cyc_last = cnt_w'(bit_cycles - 1);

  logic [10:0]      frame_q;              // Stop, parity, data, start
  logic [cnt_w-1:0] cyc_cnt;
  logic [3:0]       bit_idx;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_q <= '1;                      // Line idles high
      cyc_cnt <= '0;
      bit_idx <= '0;
      tx_busy <= 1'b0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        frame_q <= {1'b1, even_parity(tx_byte), tx_byte, 1'b0};
        cyc_cnt <= '0;
        bit_idx <= '0;
        tx_busy <= 1'b1;
      end
    end
    else if (cyc_cnt == cyc_last)
    begin
      cyc_cnt <= '0;
      frame_q <= {1'b1, frame_q[10:1]};   // Next bit, refill with idle
      if (bit_idx == 4'd10)
        tx_busy <= 1'b0;                  // Stop bit done
      else
        bit_idx <= bit_idx + 1'b1;
    end
    else
    begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  assign tx = frame_q[0];

  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx
  );

endmodule

// File: uart_rx_frame.sv
module uart_rx_frame #(
  parameter int bit_cycles = 434
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rx,
  input  logic                      rx_enable,
  output logic                      rx_done,
  output uart_cmd_pkg::frame_byte_t rx_byte,
  output logic                      rx_err
);
  import uart_cmd_pkg::*;

  localparam int cnt_w = $clog2(bit_cycles);
  localparam logic [cnt_w-1:0] cyc_last = cnt_w'(bit_cycles - 1);
  localparam logic [cnt_w-1:0] cyc_mid  = cnt_w'(bit_cycles / 2);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             busy;
  logic             start_edge;
  logic             mid_bit;
  logic [cnt_w-1:0] cyc_cnt;
  logic [3:0]       bit_idx;              // 0 start, 1..8 data, 9 parity, 10 stop
  frame_byte_t      data_q;
  logic             par_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_enable && !busy && rx_prev && !rx_sync;
  assign mid_bit    = busy && (cyc_cnt == cyc_mid);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      cyc_cnt <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (start_edge)
      begin
        busy    <= 1'b1;
        cyc_cnt <= '0;
        bit_idx <= '0;
      end
      else if (busy)
      begin
        if (cyc_cnt == cyc_last)
        begin
          cyc_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
        end
        else
        begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
        if (mid_bit && bit_idx == 4'd0 && rx_sync)
          busy <= 1'b0;                   // Glitch, not a start bit
        else if (mid_bit && bit_idx == 4'd10)
        begin
          busy    <= 1'b0;                // Free again at mid stop
          rx_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid_bit)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        data_q <= {rx_sync, data_q[7:1]};  // LSB first
      else if (bit_idx == 4'd9)
        par_q <= rx_sync;
      else if (bit_idx == 4'd10)
      begin
        rx_byte <= data_q;
        rx_err  <= (par_q != even_parity(data_q)) || !rx_sync;
      end
    end
  end

endmodule

// File: rsp_port.sv
module rsp_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rsp_load,
  input  uart_cmd_pkg::rsp_t rsp_word,
  input  logic               rsp_ack,
  output logic               rsp_req,
  output uart_cmd_pkg::rsp_t rsp,
  output logic               rsp_busy
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp_req  <= 1'b0;
      rsp_busy <= 1'b0;
    end
    else if (!rsp_busy)
    begin
      if (rsp_load)
      begin
        rsp_req  <= 1'b1;
        rsp_busy <= 1'b1;
      end
    end
    else if (rsp_req)
    begin
      if (rsp_ack)
        rsp_req <= 1'b0;                  // Host took the data
    end
    else if (!rsp_ack)
    begin
      rsp_busy <= 1'b0;                   // Ack low, handshake closed
    end
  end

  always_ff @(posedge clk)
  begin
    if (rsp_load && !rsp_busy)
      rsp <= rsp_word;
  end

  a_rsp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_req && $past(rsp_req) |-> $stable(rsp)
  );

endmodule

// File: uart_cmd_top.sv
module uart_cmd_top #(
  parameter int bit_cycles = 434          // Clocks per bit, even and at least 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               rx,
  input  logic               rsp_ack,
  output logic               cmd_ack,
  output logic               tx,
  output logic               rsp_req,
  output uart_cmd_pkg::rsp_t rsp
);
  import uart_cmd_pkg::*;

  logic        cmd_valid;
  cmd_t        held_cmd;
  logic        idle;
  logic        tx_start;
  frame_byte_t tx_byte;
  logic        tx_busy;
  logic        rx_enable;
  logic        rx_done;
  frame_byte_t rx_byte;
  logic        rx_err;
  logic        rsp_load;
  rsp_t        rsp_word;
  logic        rsp_busy;

  cmd_intake u_intake (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .idle      (idle),
    .cmd_ack   (cmd_ack),
    .cmd_valid (cmd_valid),
    .held_cmd  (held_cmd)
  );

  cmd_sequencer #(.bit_cycles(bit_cycles)) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .held_cmd  (held_cmd),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .rsp_busy  (rsp_busy),
    .idle      (idle),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_enable (rx_enable),
    .rsp_load  (rsp_load),
    .rsp_word  (rsp_word)
  );

  uart_tx_frame #(.bit_cycles(bit_cycles)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx_frame #(.bit_cycles(bit_cycles)) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_enable (rx_enable),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err)
  );

  rsp_port u_rsp (
    .clk      (clk),
    .rst_n    (rst_n),
    .rsp_load (rsp_load),
    .rsp_word (rsp_word),
    .rsp_ack  (rsp_ack),
    .rsp_req  (rsp_req),
    .rsp      (rsp),
    .rsp_busy (rsp_busy)
  );

endmodule

// File: tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;                        // Released on an edge like other inputs
  end

  always #2 clk = ~clk;                   // 4 ns period

endmodule

// File: tb_monitor.sv
module tb_monitor #(
  parameter int bit_cycles = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  logic               cmd_ack,
  input  logic               tx,
  input  logic               rsp_req,
  input  logic               rsp_ack,
  input  uart_cmd_pkg::rsp_t rsp,
  input  logic               exp_wr,
  input  logic [6:0]         exp_addr,
  input  logic [7:0]         exp_data,
  input  logic [7:0]         exp_peer,
  input  logic               exp_bad,
  output int                 frames_seen,
  output int                 errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import uart_cmd_pkg::*;

  // Start to start distance of the two write frames
  localparam longint min_spacing = (11 + gap_bits) * bit_cycles;

  int          err_cnt = 0;
  logic        tx_q;
  logic        ack_q;
  logic        req_q;
  logic        rsp_req_q;
  logic        rsp_ack_q;
  rsp_t        rsp_q;
  logic        seen_req;
  logic        in_frame;
  logic [10:0] bits;                      // Start, data LSB first, parity, stop
  int          fcnt;
  int          frames;
  longint      cyc;
  longint      frame_start;
  longint      first_start;

  assign errors = err_cnt;

  task automatic value_error(input string name, input logic [15:0] exp_v,
                             input logic [15:0] got_v);
    err_cnt = err_cnt + 1;
    $display("Fail %s expected 0x%0h got 0x%0h", name, exp_v, got_v);
  endtask

  task automatic note_error(input string msg);
    err_cnt = err_cnt + 1;
    $display("Error: %s", msg);
  endtask

  task automatic check_frame();
    logic [7:0] b;
    logic [7:0] exp_b;
    b     = bits[8:1];
    frames = frames + 1;
    if (frames == 1)
      exp_b = {exp_wr, exp_addr};         // Header byte
    else
      exp_b = exp_data;
    if (frames > (exp_wr ? 2 : 1))
      note_error("extra tx frame within one transaction");
    else if (b !== exp_b)
      value_error("tx_byte", exp_b, b);
    if (bits[0] !== 1'b0)
      value_error("tx_start_bit", 16'h0, bits[0]);
    if (bits[9] !== ^b)
      value_error("tx_parity", ^b, bits[9]);
    if (bits[10] !== 1'b1)
      value_error("tx_stop_bit", 16'h1, bits[10]);
    if (frames == 1)
      first_start = frame_start;
    else if (frames == 2 && frame_start - first_start < min_spacing)
      value_error("tx_frame_spacing", min_spacing, frame_start - first_start);
    frames_seen <= frames;
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      tx_q      = 1'b1;
      ack_q     = 1'b0;
      req_q     = 1'b0;
      rsp_req_q = 1'b0;
      rsp_ack_q = 1'b0;
      rsp_q     = '0;
      seen_req  = 1'b0;
      in_frame  = 1'b0;
      fcnt      = 0;
      frames    = 0;
      cyc       = 0;
      frames_seen <= 0;
    end
    else
    begin
      cyc = cyc + 1;
      if (cmd_req)
        seen_req = 1'b1;
      if (!seen_req)
      begin
        // Quiet outputs until the host asks for something
        if (tx !== 1'b1)
          value_error("tx", 16'h1, tx);
        if (cmd_ack !== 1'b0)
          value_error("cmd_ack", 16'h0, cmd_ack);
        if (rsp_req !== 1'b0)
          value_error("rsp_req", 16'h0, rsp_req);
      end

      if (cmd_ack && !ack_q)
      begin
        if (!req_q)
          note_error("cmd_ack rose without cmd_req");
        if (rsp_req || rsp_ack || rsp_req_q || rsp_ack_q)
          note_error("cmd_ack rose during a response handshake");
        frames = 0;                       // New transaction
        frames_seen <= 0;
      end
      if (!cmd_ack && ack_q && req_q)
        note_error("cmd_ack fell while cmd_req was high");

      if (rsp_req && !rsp_req_q)
      begin
        if (rsp_ack)
          note_error("rsp_req rose while rsp_ack was still high");
        if (exp_wr)
          note_error("response offered for a write command");
        else
        begin
          if (rsp.data !== exp_peer)
            value_error("rsp.data", exp_peer, rsp.data);
          if (rsp.err !== exp_bad)
            value_error("rsp.err", exp_bad, rsp.err);
        end
      end
      if (rsp_req && rsp_req_q && rsp !== rsp_q)
        value_error("rsp", rsp_q, rsp);   // Must hold while offered
      if (!rsp_req && rsp_req_q && !rsp_ack_q)
        note_error("rsp_req fell before rsp_ack was seen");

      if (!in_frame)
      begin
        if (tx_q && !tx)
        begin
          in_frame    = 1'b1;
          fcnt        = 0;
          frame_start = cyc;
        end
      end
      else
      begin
        fcnt = fcnt + 1;
        if (fcnt % bit_cycles == bit_cycles / 2)
          bits[fcnt / bit_cycles] = tx;   // Mid-bit sample
        if (fcnt == 10 * bit_cycles + bit_cycles / 2)
        begin
          in_frame = 1'b0;
          check_frame();
        end
      end

      tx_q      = tx;
      ack_q     = cmd_ack;
      req_q     = cmd_req;
      rsp_req_q = rsp_req;
      rsp_ack_q = rsp_ack;
      rsp_q     = rsp;
    end
  end

endmodule

// File: tb_uart_cmd.sv
module tb_uart_cmd;
  timeunit 1ns;
  timeprecision 100ps;
  import uart_cmd_pkg::*;

  localparam int bit_cycles = 8;
  localparam int wait_limit = 50 * bit_cycles;

  logic             clk;
  logic             rst_n;
  logic             cmd_req;
  cmd_t             cmd;
  logic             rx;
  logic             rsp_ack;
  logic             cmd_ack;
  logic             tx;
  logic             rsp_req;
  rsp_t             rsp;
  logic             exp_wr;
  logic [6:0]       exp_addr;
  logic [7:0]       exp_data;
  logic [7:0]       exp_peer;
  logic             exp_bad;
  int               frames_seen;
  int               errors;
  int               timeouts;
  int               tests_run;
  logic [31:0]      rnd_state;
  logic             ack_armed;
  int               ack_delay;
  int               ack_hold;
  int               fd;
  int               n;
  logic [8*80-1:0]  line_buf;
  logic [7:0]       op_c;
  logic [7:0]       t_addr;
  logic [7:0]       t_data;
  logic [7:0]       t_peer;
  logic [3:0]       t_bad;

  tb_clock u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_top #(.bit_cycles(bit_cycles)) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .rx      (rx),
    .rsp_ack (rsp_ack),
    .cmd_ack (cmd_ack),
    .tx      (tx),
    .rsp_req (rsp_req),
    .rsp     (rsp)
  );

  tb_monitor #(.bit_cycles(bit_cycles)) u_mon (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_req     (cmd_req),
    .cmd_ack     (cmd_ack),
    .tx          (tx),
    .rsp_req     (rsp_req),
    .rsp_ack     (rsp_ack),
    .rsp         (rsp),
    .exp_wr      (exp_wr),
    .exp_addr    (exp_addr),
    .exp_data    (exp_data),
    .exp_peer    (exp_peer),
    .exp_bad     (exp_bad),
    .frames_seen (frames_seen),
    .errors      (errors)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_reset();
    int k;
    k = 0;
    while (rst_n !== 1'b1 && k < 20)
    begin
      @(posedge clk);
      k++;
    end
    if (rst_n !== 1'b1)
    begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
  endtask

  task automatic wait_cmd_ack(input logic level);
    int k;
    k = 0;
    while (cmd_ack !== level && k < wait_limit)
    begin
      @(posedge clk);
      k++;
    end
    if (cmd_ack !== level)
    begin
      timeouts++;
      $display("Timeout: cmd_ack never went to %0b", level);
    end
  endtask

  task automatic wait_rsp_req(input logic level);
    int k;
    k = 0;
    while (rsp_req !== level && k < wait_limit)
    begin
      @(posedge clk);
      k++;
    end
    if (rsp_req !== level)
    begin
      timeouts++;
      $display("Timeout: rsp_req never went to %0b", level);
    end
  endtask

  task automatic wait_frames(input int count);
    int k;
    k = 0;
    while (frames_seen < count && k < wait_limit)
    begin
      @(posedge clk);
      k++;
    end
    if (frames_seen < count)
    begin
      timeouts++;
      $display("Timeout: only %0d of %0d tx frames arrived", frames_seen, count);
    end
  endtask

  // Serial peer answering a read header
  task automatic send_peer(input logic [7:0] b, input logic bad);
    logic [10:0] f;
    f = {1'b1, (^b) ^ bad, b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx <= f[i];
      repeat (bit_cycles) @(posedge clk);
    end
  endtask

  task automatic run_test(input logic wr, input logic [6:0] a, input logic [7:0] d,
                          input logic [7:0] p, input logic bad);
    @(posedge clk);
    exp_wr   <= wr;
    exp_addr <= a;
    exp_data <= d;
    exp_peer <= p;
    exp_bad  <= bad;
    cmd      <= {wr, a, d};
    cmd_req  <= 1'b1;
    wait_cmd_ack(1'b1);
    cmd_req  <= 1'b0;
    wait_cmd_ack(1'b0);
    wait_frames(wr ? 2 : 1);
    if (!wr && timeouts == 0)
    begin
      send_peer(p, bad);
      wait_rsp_req(1'b1);                 // Next command may overlap the ack
    end
  endtask

  // Host side of the response handshake, ack after a random delay
  initial
  begin
    rsp_ack   <= 1'b0;
    rnd_state = 32'h5e4d;
    ack_armed = 1'b0;
    ack_delay = 0;
    ack_hold  = 0;
    forever
    begin
      @(posedge clk);
      if (rsp_ack)
      begin
        if (!rsp_req)
        begin
          rsp_ack  <= 1'b0;               // Last phase
          ack_hold = 0;
        end
        else
        begin
          ack_hold++;
          if (ack_hold == wait_limit)
          begin
            timeouts++;
            $display("Timeout: rsp_req never dropped after rsp_ack");
          end
        end
      end
      else if (rsp_req)
      begin
        if (!ack_armed)
        begin
          rnd_state = next_random(rnd_state);
          ack_delay = rnd_state[3:0];     // 0 to 15 cycles
          ack_armed = 1'b1;
        end
        if (ack_delay == 0)
        begin
          rsp_ack   <= 1'b1;
          ack_armed = 1'b0;
        end
        else
        begin
          ack_delay--;
        end
      end
    end
  end

  initial
  begin
    cmd_req   <= 1'b0;
    cmd       <= '0;
    rx        <= 1'b1;
    exp_wr    <= 1'b0;
    exp_addr  <= '0;
    exp_data  <= '0;
    exp_peer  <= '0;
    exp_bad   <= 1'b0;
    timeouts  = 0;
    tests_run = 0;
    wait_reset();
    repeat (bit_cycles) @(posedge clk);   // Idle stretch after reset
    fd = $fopen("uart_cmd_tests.txt", "r");
    if (fd == 0)
      $display("Could not open uart_cmd_tests.txt");
    else
    begin
      while (!$feof(fd) && timeouts == 0)
      begin
        n = $fgets(line_buf, fd);
        if (n > 0)
          n = $sscanf(line_buf, "%s %h %h %h %h", op_c, t_addr, t_data, t_peer, t_bad);
        if (n == 5 && (op_c == "W" || op_c == "R"))
        begin
          run_test(op_c == "W", t_addr[6:0], t_data, t_peer, t_bad[0]);
          tests_run++;
        end
      end
      $fclose(fd);
    end
    wait_rsp_req(1'b0);                   // Let a last response close
    repeat (2) @(posedge clk);
    $display("Errors %0d, timeouts %0d, tests run %0d", errors, timeouts, tests_run);
    if (errors == 0 && timeouts == 0 && tests_run > 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: uart_cmd.f
uart_cmd_pkg.sv
cmd_intake.sv
cmd_sequencer.sv
uart_tx_frame.sv
uart_rx_frame.sv
rsp_port.sv
uart_cmd_top.sv
tb_clock.sv
tb_monitor.sv
tb_uart_cmd.sv

// File: uart_cmd_tests.txt
# op addr data peer bad_parity, all hex
# W sends header then data, R expects the peer byte back
W 12 a5 00 0
R 12 00 3c 0
W 7f ff 00 0
R 00 00 81 1
W 00 00 00 0
R 55 00 ff 0
R 2a 00 00 1
W 41 5a 00 0
R 7f 00 c3 0
W 3b 96 00 0
R 09 00 7e 1
R 64 00 10 0
